// File: verilog/fp_pkg.sv
// ----------------------------------------
// widths, opcodes and sequencer states
// shared by the FPU control subsystem
// ----------------------------------------
`default_nettype none

package fp_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------

	// memory word and address
	localparam int WORD_W  = 16;
	localparam int ADDR_W  = 8;
	// accumulator holds two words
	localparam int ACC_W   = 32;
	// normalize count, up to 31 shifts
	localparam int SHIFT_W = 5;

	// ----------------------------------------
	// opcodes and states
	// ----------------------------------------

	typedef enum logic [1:0] {
		OP_LD  = 2'd0,
		OP_AD  = 2'd1,
		OP_SD  = 2'd2,
		OP_NRF = 2'd3
	} fp_op_e;

	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,
		ST_DLY      = 3'd1,
		ST_RD_HI    = 3'd2,
		ST_RD_LO    = 3'd3,
		ST_EXEC     = 3'd4,
		ST_WAIT_ALU = 3'd5,
		ST_DONE     = 3'd6
	} fp_state_e;

endpackage

`default_nettype wire

// File: verilog/word_mem.sv
// ----------------------------------------
// single-port word memory, registered read
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module word_mem #(
	parameter int WORD_W = 16,
	parameter int ADDR_W = 8
) (
	input  wire logic              got_fp,
	input  wire logic              me,
	input  wire logic              we,
	input  wire logic [ADDR_W-1:0] addr,
	input  wire logic [WORD_W-1:0] wdata,
	output logic      [WORD_W-1:0] rdata
);

	logic [WORD_W-1:0] mem [2**ADDR_W];

	// write wins, read data shows up next cycle
	always_ff @(posedge got_fp) begin
		if (me) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
// ----------------------------------------
// fixed-priority memory arbiter
// host writes ahead of sequencer reads
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
	parameter int WORD_W = 16,
	parameter int ADDR_W = 8
) (
	input  wire logic              got_fp,
	input  wire logic              _0_f,
	// host write port
	input  wire logic              hm_valid,
	input  wire logic [ADDR_W-1:0] hm_addr,
	input  wire logic [WORD_W-1:0] hm_wdata,
	output logic                   hm_ready,
	// sequencer read port
	input  wire logic              rq_valid,
	input  wire logic [ADDR_W-1:0] rq_addr,
	output logic                   rq_ready,
	output logic                   rd_valid,
	output logic      [WORD_W-1:0] rd_data,
	// memory side
	input  wire logic [WORD_W-1:0] rdata,
	output logic                   me,
	output logic                   we,
	output logic      [ADDR_W-1:0] addr,
	output logic      [WORD_W-1:0] wdata
);

	logic rd_pend;

	// memory completes every access in one cycle
	assign hm_ready = 1'b1;
	assign rq_ready = ~hm_valid;

	assign me    = hm_valid | rq_valid;
	assign we    = hm_valid;
	assign addr  = hm_valid ? hm_addr : rq_addr;
	assign wdata = hm_wdata;

	// read in flight, data returns next cycle
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			rd_pend <= 1'b0;
		else
			rd_pend <= rq_valid & rq_ready;
	end

	assign rd_valid = rd_pend;
	assign rd_data  = rdata;

endmodule

`default_nettype wire

// File: verilog/fp_alu.sv
// ----------------------------------------
// accumulator datapath: load, add, sub
// and a bit-serial normalizer
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_alu
	import fp_pkg::*;
(
	input  wire logic               got_fp,
	input  wire logic               _0_f,
	input  wire logic               alu_start,
	input  wire fp_op_e             alu_op,
	input  wire logic [ACC_W-1:0]   alu_operand,
	output logic                    alu_done,
	output logic      [ACC_W-1:0]   acc,
	output logic                    carry,
	output logic      [SHIFT_W-1:0] shift_cnt
);

	logic norm_busy;
	logic normed;

	// msb set, or nothing left to shift
	assign normed = acc[ACC_W-1] | ~|acc;

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			acc       <= '0;
			carry     <= 1'b0;
			shift_cnt <= '0;
			alu_done  <= 1'b0;
			norm_busy <= 1'b0;
		end else begin
			alu_done <= 1'b0;

			if (norm_busy) begin
				// one bit per cycle
				if (normed) begin
					norm_busy <= 1'b0;
					alu_done  <= 1'b1;
				end else begin
					acc       <= acc << 1;
					shift_cnt <= shift_cnt + 1'b1;
				end
			end else if (alu_start) begin
				shift_cnt <= '0;
				case (alu_op)
					OP_LD: begin
						acc      <= alu_operand;
						carry    <= 1'b0;
						alu_done <= 1'b1;
					end
					OP_AD: begin
						// carry out lands in the extra bit
						{carry, acc} <= {1'b0, acc} + {1'b0, alu_operand};
						alu_done     <= 1'b1;
					end
					OP_SD: begin
						// top bit of the wide difference is the borrow
						{carry, acc} <= {1'b0, acc} - {1'b0, alu_operand};
						alu_done     <= 1'b1;
					end
					OP_NRF: begin
						// carry is left alone
						if (normed)
							alu_done <= 1'b1;
						else
							norm_busy <= 1'b1;
					end
					default: begin
						alu_done <= 1'b1;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fp_seq.sv
// ----------------------------------------
// job sequencer: operand fetch, ALU start
// and result hand-off
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_seq
	import fp_pkg::*;
#(
	parameter int WORD_W = fp_pkg::WORD_W,
	parameter int ADDR_W = fp_pkg::ADDR_W
) (
	input  wire logic               got_fp,
	input  wire logic               _0_f,
	// job port
	input  wire logic               job_valid,
	input  wire fp_op_e             job_op,
	input  wire logic [ADDR_W-1:0]  job_addr,
	output logic                    job_ready,
	// done port
	input  wire logic               done_ready,
	output logic                    done_valid,
	output logic      [ACC_W-1:0]   res_acc,
	output logic                    res_carry,
	output logic      [SHIFT_W-1:0] res_shift,
	// memory read port
	input  wire logic               rq_ready,
	input  wire logic               rd_valid,
	input  wire logic [WORD_W-1:0]  rd_data,
	output logic                    rq_valid,
	output logic      [ADDR_W-1:0]  rq_addr,
	// ALU
	input  wire logic               alu_done,
	input  wire logic [ACC_W-1:0]   acc,
	input  wire logic               carry,
	input  wire logic [SHIFT_W-1:0] shift_cnt,
	output logic                    alu_start,
	output fp_op_e                  alu_op,
	output logic      [ACC_W-1:0]   alu_operand
);

	fp_state_e         st;
	logic              rd_wait;
	logic              word_cnt;
	fp_op_e            op_q;
	logic [ADDR_W-1:0] base_q;
	logic [WORD_W-1:0] op_hi;
	logic [WORD_W-1:0] op_lo;

	// ----------------------------------------
	// control
	// ----------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			st       <= ST_IDLE;
			rd_wait  <= 1'b0;
			word_cnt <= 1'b0;
		end else begin
			case (st)
				ST_IDLE: begin
					if (job_valid) begin
						word_cnt <= 1'b0;
						st       <= ST_DLY;
					end
				end
				// one-cycle start delay
				ST_DLY: begin
					st <= (op_q == OP_NRF) ? ST_EXEC : ST_RD_HI;
				end
				ST_RD_HI, ST_RD_LO: begin
					if (!rd_wait) begin
						if (rq_ready)
							rd_wait <= 1'b1;
					end else if (rd_valid) begin
						rd_wait  <= 1'b0;
						word_cnt <= 1'b1;
						st       <= (st == ST_RD_HI) ? ST_RD_LO : ST_EXEC;
					end
				end
				ST_EXEC: begin
					st <= ST_WAIT_ALU;
				end
				ST_WAIT_ALU: begin
					if (alu_done)
						st <= ST_DONE;
				end
				ST_DONE: begin
					if (done_ready)
						st <= ST_IDLE;
				end
				default: begin
					st <= ST_IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------
	// job, operand and result registers
	// ----------------------------------------

	always_ff @(posedge got_fp) begin
		if (st == ST_IDLE && job_valid) begin
			op_q   <= job_op;
			base_q <= job_addr;
		end
		if (rd_wait && rd_valid) begin
			if (st == ST_RD_HI)
				op_hi <= rd_data;
			else
				op_lo <= rd_data;
		end
		// hold results until taken
		if (st == ST_WAIT_ALU && alu_done) begin
			res_acc   <= acc;
			res_carry <= carry;
			res_shift <= shift_cnt;
		end
	end

	assign job_ready  = (st == ST_IDLE);
	assign done_valid = (st == ST_DONE);

	// high word first, then the next address
	assign rq_valid = (st == ST_RD_HI || st == ST_RD_LO) && !rd_wait;
	assign rq_addr  = base_q + ADDR_W'(word_cnt);

	assign alu_start   = (st == ST_EXEC);
	assign alu_op      = op_q;
	assign alu_operand = {op_hi, op_lo};

endmodule

`default_nettype wire

// File: verilog/fps_top.sv
// ----------------------------------------
// FPU control subsystem top level
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fps_top
	import fp_pkg::*;
#(
	parameter int WORD_W = fp_pkg::WORD_W,
	parameter int ADDR_W = fp_pkg::ADDR_W
) (
	input  wire logic               got_fp,
	input  wire logic               _0_f,
	input  wire logic               job_valid,
	input  wire fp_op_e             job_op,
	input  wire logic [ADDR_W-1:0]  job_addr,
	output logic                    job_ready,
	input  wire logic               done_ready,
	output logic                    done_valid,
	output logic      [ACC_W-1:0]   res_acc,
	output logic                    res_carry,
	output logic      [SHIFT_W-1:0] res_shift,
	input  wire logic               hm_valid,
	input  wire logic [ADDR_W-1:0]  hm_addr,
	input  wire logic [WORD_W-1:0]  hm_wdata,
	output logic                    hm_ready
);

	// sequencer to arbiter
	logic              rq_valid, rq_ready, rd_valid;
	logic [ADDR_W-1:0] rq_addr;
	logic [WORD_W-1:0] rd_data;

	// sequencer to ALU
	logic               alu_start, alu_done, carry;
	fp_op_e             alu_op;
	logic [ACC_W-1:0]   alu_operand, acc;
	logic [SHIFT_W-1:0] shift_cnt;

	// arbiter to memory
	logic              me, we;
	logic [ADDR_W-1:0] addr;
	logic [WORD_W-1:0] wdata, rdata;

	fp_seq #(.WORD_W(WORD_W), .ADDR_W(ADDR_W)) u_fp_seq (
		.got_fp(got_fp), ._0_f(_0_f),
		.job_valid(job_valid), .job_op(job_op), .job_addr(job_addr),
		.job_ready(job_ready), .done_ready(done_ready), .done_valid(done_valid),
		.res_acc(res_acc), .res_carry(res_carry), .res_shift(res_shift),
		.rq_ready(rq_ready), .rd_valid(rd_valid), .rd_data(rd_data),
		.rq_valid(rq_valid), .rq_addr(rq_addr),
		.alu_done(alu_done), .acc(acc), .carry(carry), .shift_cnt(shift_cnt),
		.alu_start(alu_start), .alu_op(alu_op), .alu_operand(alu_operand)
	);

	fp_alu u_fp_alu (
		.got_fp(got_fp), ._0_f(_0_f),
		.alu_start(alu_start), .alu_op(alu_op), .alu_operand(alu_operand),
		.alu_done(alu_done), .acc(acc), .carry(carry), .shift_cnt(shift_cnt)
	);

	mem_arbiter #(.WORD_W(WORD_W), .ADDR_W(ADDR_W)) u_mem_arbiter (
		.got_fp(got_fp), ._0_f(_0_f),
		.hm_valid(hm_valid), .hm_addr(hm_addr), .hm_wdata(hm_wdata),
		.hm_ready(hm_ready),
		.rq_valid(rq_valid), .rq_addr(rq_addr), .rq_ready(rq_ready),
		.rd_valid(rd_valid), .rd_data(rd_data),
		.rdata(rdata), .me(me), .we(we), .addr(addr), .wdata(wdata)
	);

	word_mem #(.WORD_W(WORD_W), .ADDR_W(ADDR_W)) u_word_mem (
		.got_fp(got_fp),
		.me(me), .we(we), .addr(addr), .wdata(wdata),
		.rdata(rdata)
	);

endmodule

`default_nettype wire

// File: dv/tb_fps_model.svh
// ----------------------------------------
// reference model: memory image, accumulator
// and LFSR for the FPU control testbench
// ----------------------------------------
`ifndef TB_FPS_MODEL_SVH
`define TB_FPS_MODEL_SVH

logic [WORD_W-1:0]  mem_img [2**ADDR_W];
logic [ACC_W-1:0]   acc_m   = '0;
logic               carry_m = 1'b0;
logic [SHIFT_W-1:0] shift_m = '0;
logic [31:0]        lfsr    = 32'hbb38_ce6d;

// fibonacci, taps 32 22 2 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic        fb;
	int          i;
	r = '0;
	for (i = 0; i < n; i++) begin
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		r    = {r[30:0], fb};
	end
	return r;
endfunction

// even base address in the low or high half
function automatic logic [ADDR_W-1:0] pair_addr(input logic half);
	logic [ADDR_W-1:0] a;
	a = ADDR_W'(rand_bits(ADDR_W-2)) << 1;
	a[ADDR_W-1] = half;
	return a;
endfunction

// high word at the base, low word right after it
function automatic logic [ACC_W-1:0] operand_at(input logic [ADDR_W-1:0] a);
	logic [ADDR_W-1:0] a_lo;
	a_lo = a + 1'b1;
	return {mem_img[a], mem_img[a_lo]};
endfunction

function automatic void model_op(input fp_op_e op, input logic [ACC_W-1:0] opnd);
	shift_m = '0;
	case (op)
		OP_LD: begin
			acc_m   = opnd;
			carry_m = 1'b0;
		end
		OP_AD: begin
			// sum wraps below acc on a carry out
			carry_m = (acc_m + opnd) < acc_m;
			acc_m   = acc_m + opnd;
		end
		OP_SD: begin
			carry_m = acc_m < opnd;
			acc_m   = acc_m - opnd;
		end
		default: begin
			// count leading zeros, zero stays put
			while (acc_m != '0 && !acc_m[ACC_W-1]) begin
				acc_m   = acc_m << 1;
				shift_m = shift_m + 1'b1;
			end
		end
	endcase
endfunction

`endif

// File: dv/tb_fps.sv
// ----------------------------------------
// testbench for the FPU control subsystem
// random jobs and host writes against a model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_fps
	import fp_pkg::*;
();

	localparam int N_LD     = 16;
	localparam int N_AD     = 16;
	localparam int N_SD     = 16;
	localparam int N_NRF    = 12;
	localparam int N_ARB    = 16;
	localparam int N_BP     = 16;
	localparam int N_JOBS   = N_LD + N_AD + N_SD + 2 * N_NRF + 2 * N_ARB + N_BP;
	localparam int N_WRITES = 2**ADDR_W + 1 + 3 * N_NRF;
	// a job never needs more than 64 cycles
	localparam int MAX_CYC  = N_JOBS * 64 + N_WRITES * 2 + 100;

	logic               got_fp = 1'b0;
	logic               _0_f;
	logic               job_valid;
	fp_op_e             job_op;
	logic [ADDR_W-1:0]  job_addr;
	logic               job_ready;
	logic               done_ready;
	logic               done_valid;
	logic [ACC_W-1:0]   res_acc;
	logic               res_carry;
	logic [SHIFT_W-1:0] res_shift;
	logic               hm_valid;
	logic [ADDR_W-1:0]  hm_addr;
	logic [WORD_W-1:0]  hm_wdata;
	logic               hm_ready;

	int cycles = 0;
	int checks = 0;
	int errors = 0;

	`include "tb_fps_model.svh"

	fps_top #(.WORD_W(WORD_W), .ADDR_W(ADDR_W)) u_fps_top (
		.got_fp(got_fp), ._0_f(_0_f),
		.job_valid(job_valid), .job_op(job_op), .job_addr(job_addr),
		.job_ready(job_ready), .done_ready(done_ready), .done_valid(done_valid),
		.res_acc(res_acc), .res_carry(res_carry), .res_shift(res_shift),
		.hm_valid(hm_valid), .hm_addr(hm_addr), .hm_wdata(hm_wdata),
		.hm_ready(hm_ready)
	);

	always #50 got_fp = ~got_fp;

	always @(posedge got_fp) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYC) begin
			$display("timeout: no result after %0d cycles, the run is stopped", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	task automatic check_eq(input string what, input logic [ACC_W-1:0] got,
			input logic [ACC_W-1:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// record the last accepted write and maybe start another
	task automatic host_step(input logic want, input logic [ADDR_W-1:0] a,
			input logic [WORD_W-1:0] d);
		if (hm_valid) begin
			check_eq("hm_ready", hm_ready, 1);
			if (hm_ready)
				mem_img[hm_addr] = hm_wdata;
		end
		hm_valid = 1'b0;
		if (want) begin
			hm_valid = 1'b1;
			hm_addr  = a;
			hm_wdata = d;
		end
	endtask

	task automatic run_job(input fp_op_e op, input logic [ADDR_W-1:0] a,
			input logic arb, input logic bp);
		logic [ACC_W-1:0]   e_acc;
		logic               e_carry;
		logic [SHIFT_W-1:0] e_shift;
		int                 hold;
		logic               taken;
		model_op(op, operand_at(a));
		e_acc   = acc_m;
		e_carry = carry_m;
		e_shift = shift_m;
		@(negedge got_fp);
		while (!job_ready)
			@(negedge got_fp);
		job_valid = 1'b1;
		job_op    = op;
		job_addr  = a;
		@(negedge got_fp);
		job_valid = 1'b0;
		hold  = bp ? int'(rand_bits(3)) : 0;
		taken = 1'b0;
		while (!taken) begin
			host_step(arb && rand_bits(2) == 0, pair_addr(1'b1), WORD_W'(rand_bits(WORD_W)));
			if (done_valid) begin
				// checked every cycle, so a held result must not move
				check_eq("res_acc", res_acc, e_acc);
				check_eq("res_carry", res_carry, e_carry);
				check_eq("res_shift", res_shift, e_shift);
				check_eq("job_ready during done", job_ready, 0);
				if (hold == 0) begin
					done_ready = 1'b1;
					taken      = 1'b1;
				end else begin
					hold--;
				end
			end
			@(negedge got_fp);
		end
		done_ready = 1'b0;
		// one result per job
		check_eq("done_valid after hand-off", done_valid, 0);
		host_step(1'b0, '0, '0);
	endtask

	task automatic report(input string name, input int err_before);
		if (errors == err_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_before);
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------

	initial begin
		int                 i;
		int                 base_err;
		logic [ACC_W-1:0]   opnd;
		logic [ADDR_W-1:0]  a;
		job_valid  = 1'b0;
		job_op     = OP_LD;
		job_addr   = '0;
		done_ready = 1'b0;
		hm_valid   = 1'b0;
		hm_addr    = '0;
		hm_wdata   = '0;
		_0_f       = 1'b1;
		repeat (4) @(posedge got_fp);
		@(negedge got_fp);
		check_eq("job_ready in reset", job_ready, 1);
		check_eq("done_valid in reset", done_valid, 0);
		_0_f = 1'b0;

		// load over a fully written memory
		base_err = errors;
		for (i = 0; i < 2**ADDR_W; i++) begin
			@(negedge got_fp);
			host_step(1'b1, ADDR_W'(i), WORD_W'(rand_bits(WORD_W)));
		end
		@(negedge got_fp);
		host_step(1'b0, '0, '0);
		for (i = 0; i < N_LD; i++)
			run_job(OP_LD, ADDR_W'(rand_bits(ADDR_W)), 1'b0, 1'b0);
		report("load", base_err);

		base_err = errors;
		for (i = 0; i < N_AD; i++)
			run_job(OP_AD, ADDR_W'(rand_bits(ADDR_W)), 1'b0, 1'b0);
		report("add", base_err);

		base_err = errors;
		for (i = 0; i < N_SD; i++)
			run_job(OP_SD, ADDR_W'(rand_bits(ADDR_W)), 1'b0, 1'b0);
		report("subtract", base_err);

		// zero, normalized and short values
		base_err = errors;
		for (i = 0; i < N_NRF; i++) begin
			case (i % 4)
				0:       opnd = '0;
				1:       opnd = rand_bits(ACC_W) | 32'h8000_0000;
				default: opnd = rand_bits(ACC_W) >> rand_bits(SHIFT_W);
			endcase
			a = pair_addr(1'b0);
			@(negedge got_fp);
			host_step(1'b1, a, opnd[ACC_W-1:WORD_W]);
			@(negedge got_fp);
			host_step(1'b1, a + 1'b1, opnd[WORD_W-1:0]);
			@(negedge got_fp);
			host_step(1'b0, '0, '0);
			run_job(OP_LD, a, 1'b0, 1'b0);
			run_job(OP_NRF, a, 1'b0, 1'b0);
		end
		report("normalize", base_err);

		// host writes to the high half while jobs read the low half
		base_err = errors;
		for (i = 0; i < N_ARB; i++)
			run_job(fp_op_e'(rand_bits(2) % 3), pair_addr(1'b0), 1'b1, 1'b0);
		for (i = 0; i < N_ARB; i++)
			run_job(OP_LD, pair_addr(1'b1), 1'b0, 1'b0);
		report("arbitration", base_err);

		base_err = errors;
		for (i = 0; i < N_BP; i++)
			run_job(fp_op_e'(rand_bits(2)), pair_addr(1'b0), 1'b0, 1'b1);
		report("back-pressure", base_err);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+dv
verilog/fp_pkg.sv
verilog/word_mem.sv
verilog/mem_arbiter.sv
verilog/fp_alu.sv
verilog/fp_seq.sv
verilog/fps_top.sv
dv/tb_fps.sv

// File: Bender.yml
package:
  name: fps

sources:
  - verilog/fp_pkg.sv
  - verilog/word_mem.sv
  - verilog/mem_arbiter.sv
  - verilog/fp_alu.sv
  - verilog/fp_seq.sv
  - verilog/fps_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_fps.sv
